//--- project.f
+incdir+include
hdl/secp256k1_pkg.sv
hdl/karatsuba_mult.sv
hdl/mod_p_fold.sv
hdl/mod_n_barrett.sv
hdl/result_merge.sv
hdl/secp256k1_mult_mod.sv
dv/tb_modmul_pkg.sv
dv/tb_modmul.sv

//--- Bender.yml
package:
  name: secp256k1_mult_mod

export_include_dirs:
  - include

sources:
  - hdl/secp256k1_pkg.sv
  - hdl/karatsuba_mult.sv
  - hdl/mod_p_fold.sv
  - hdl/mod_n_barrett.sv
  - hdl/result_merge.sv
  - hdl/secp256k1_mult_mod.sv
  - target: simulation
    files:
      - dv/tb_modmul_pkg.sv
      - dv/tb_modmul.sv

//--- dv/tb_modmul.sv
// testbench for the secp256k1 modular multiplier: edge and random products, ordered scoreboard
`timescale 1ns/1ps

module tb_modmul;

  localparam int LAT      = 6;    // accept to o_val, no back-pressure
  localparam int SB_DEPTH = 256;  // scoreboard ring

  logic                    i_clk, i_rst, i_val, o_rdy, i_rdy, o_val;
  secp256k1_pkg::mul_req_t i_req;
  secp256k1_pkg::mod_res_t o_res;

  secp256k1_pkg::mod_res_t sb [SB_DEPTH];  // expected, in acceptance order
  int unsigned             wr_ptr, rd_ptr;
  logic [31:0]             stim_s, rdy_s;  // two lfsr states
  logic                    rdy_rand, lat_chk;
  int unsigned             cyc, cyc_end, err_base;
  secp256k1_pkg::tag_t     tag_cnt;

  secp256k1_mult_mod dut_i (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_req (i_req),
    .i_val (i_val),
    .o_rdy (o_rdy),
    .o_res (o_res),
    .o_val (o_val),
    .i_rdy (i_rdy)
  );

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  // sink side, random stalls when asked
  always @(posedge i_clk) begin
    i_rdy <= rdy_rand ? tb_modmul_pkg::lfsr_bit(rdy_s) : 1'b1;
    if (!i_rst && o_val && i_rdy) rd_ptr <= rd_ptr + 1;  // result taken
  end

  // watchdog, deadline set per test
  always @(posedge i_clk) begin
    cyc <= cyc + 1;
    if (cyc > cyc_end) begin
      $display("timeout at %0t: %0d results seen of %0d requests", $time, rd_ptr, wr_ptr);
      $display("Test failed");
      $finish;
    end
  end

  task automatic report_mismatch(input string what, input logic [255:0] got, exp);
    $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
    tb_modmul_pkg::err_cnt++;
  endtask

  task automatic report_failure(input string msg);
    $display("error at %0t: %s", $time, msg);
    tb_modmul_pkg::err_cnt++;
  endtask

  a_res: assert property (@(posedge i_clk) disable iff (i_rst)
    o_val && i_rdy |-> o_res.res == sb[rd_ptr % SB_DEPTH].res)
    else report_mismatch("residue", $sampled(o_res.res), $sampled(sb[rd_ptr % SB_DEPTH].res));
  a_tag: assert property (@(posedge i_clk) disable iff (i_rst)
    o_val && i_rdy |-> o_res.tag == sb[rd_ptr % SB_DEPTH].tag)
    else report_mismatch("tag", $sampled(o_res.tag), $sampled(sb[rd_ptr % SB_DEPTH].tag));
  a_err: assert property (@(posedge i_clk) disable iff (i_rst)
    o_val && i_rdy |-> o_res.err == sb[rd_ptr % SB_DEPTH].err)
    else report_mismatch("err bit", $sampled(o_res.err), $sampled(sb[rd_ptr % SB_DEPTH].err));
  a_extra: assert property (@(posedge i_clk) disable iff (i_rst) o_val |-> rd_ptr < wr_ptr)
    else report_failure("result came out with no request outstanding");
  a_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    o_val && !i_rdy |=> o_val && $stable(o_res))
    else report_failure("output changed or dropped while stalled");
  a_rst: assert property (@(posedge i_clk) i_rst |=> !o_val)
    else report_failure("o_val high right after reset");
  a_lat: assert property (@(posedge i_clk) disable iff (i_rst)
    lat_chk && i_val && o_rdy |=> !o_val [*LAT-1] ##1 o_val)
    else report_failure("single result not seen exactly 6 cycles after acceptance");

  // hold one request until taken, then log what should come back
  task automatic issue(input secp256k1_pkg::word_t a, b, input logic sel, err);
    secp256k1_pkg::mul_req_t r;
    r = '{a: a, b: b, sel: secp256k1_pkg::mod_sel_e'(sel), tag: tag_cnt, err: err};
    tag_cnt = tag_cnt + 1;
    i_req <= r;
    i_val <= 1'b1;
    do @(posedge i_clk); while (!o_rdy);
    sb[wr_ptr % SB_DEPTH] = tb_modmul_pkg::expect_res(r);
    wr_ptr = wr_ptr + 1;
  endtask

  // sel_mode 0 = p, 1 = n, 2 = random interleave
  task automatic issue_random(input int n, input int sel_mode);
    logic sel;
    for (int i = 0; i < n; i++) begin
      sel = (sel_mode == 2) ? tb_modmul_pkg::lfsr_bit(stim_s) : sel_mode[0];
      issue(tb_modmul_pkg::lfsr_word(stim_s), tb_modmul_pkg::lfsr_word(stim_s), sel,
            tb_modmul_pkg::lfsr_bit(stim_s));
    end
  endtask

  task automatic begin_test(input int n, input logic rdy_mode, input logic lat);
    cyc_end  = cyc + (n + LAT) * 4;
    err_base = tb_modmul_pkg::err_cnt;
    rdy_rand <= rdy_mode;
    lat_chk  <= lat;
  endtask

  // drain, idle a little to catch stray results, then one line
  task automatic finish_test(input int num, input string name, input int n);
    int unsigned errs;
    i_val   <= 1'b0;
    lat_chk <= 1'b0;
    while (rd_ptr != wr_ptr) @(posedge i_clk);
    repeat (LAT + 2) @(posedge i_clk);
    errs = tb_modmul_pkg::err_cnt - err_base;
    tb_modmul_pkg::test_cnt++;
    if (errs != 0) tb_modmul_pkg::test_bad++;
    $display("test %0d %s: %0d requests, %0d errors", num, name, n, errs);
  endtask

  initial begin
    i_rst    = 1'b1;
    i_val    = 1'b0;
    i_req    = '0;
    i_rdy    = 1'b1;
    rdy_rand = 1'b0;
    lat_chk  = 1'b0;
    wr_ptr   = 0;
    rd_ptr   = 0;
    cyc      = 0;
    cyc_end  = 100;  // covers reset
    tag_cnt  = '0;
    stim_s   = tb_modmul_pkg::LFSR_SEED;
    rdy_s    = tb_modmul_pkg::LFSR_SEED;
    repeat (2) @(posedge i_clk);
    i_rst <= 1'b0;
    @(posedge i_clk);

    begin_test(24, 1'b0, 1'b0);
    issue('0, tb_modmul_pkg::lfsr_word(stim_s), secp256k1_pkg::MOD_P, 1'b0);
    issue(256'd1, tb_modmul_pkg::lfsr_word(stim_s), secp256k1_pkg::MOD_P, 1'b0);
    issue(secp256k1_pkg::P_MOD - 1, secp256k1_pkg::P_MOD - 1, secp256k1_pkg::MOD_P, 1'b0);
    issue(secp256k1_pkg::P_MOD - 1, 256'd1, secp256k1_pkg::MOD_P, 1'b1);
    issue_random(20, 0);
    finish_test(1, "mod p", 24);

    begin_test(23, 1'b0, 1'b0);
    issue(secp256k1_pkg::N_MOD - 1, secp256k1_pkg::N_MOD - 1, secp256k1_pkg::MOD_N, 1'b0);
    issue('0, secp256k1_pkg::N_MOD - 1, secp256k1_pkg::MOD_N, 1'b1);
    issue(256'd1, secp256k1_pkg::N_MOD - 1, secp256k1_pkg::MOD_N, 1'b0);
    issue_random(20, 1);
    finish_test(2, "mod n", 23);

    begin_test(24, 1'b0, 1'b0);
    issue_random(24, 2);
    finish_test(3, "ordering and tags", 24);

    begin_test(24, 1'b0, 1'b0);
    issue_random(24, 2);  // err drawn at random per request
    finish_test(4, "err pass-through", 24);

    begin_test(32, 1'b1, 1'b0);
    issue_random(32, 2);
    finish_test(5, "back-pressure", 32);

    begin_test(1, 1'b0, 1'b1);
    issue_random(1, 2);
    finish_test(6, "reset and latency", 1);

    $display("summary: %0d tests, %0d with errors, %0d check errors",
             tb_modmul_pkg::test_cnt, tb_modmul_pkg::test_bad, tb_modmul_pkg::err_cnt);
    if (tb_modmul_pkg::test_bad == 0 && tb_modmul_pkg::err_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- dv/tb_modmul_pkg.sv
// modmul testbench support: lfsr stimulus, reference model for products, run counters
package tb_modmul_pkg;

  localparam logic [31:0] LFSR_SEED = 32'h2839_99dd;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;  // x^32 + x^22 + x^2 + x + 1

  int unsigned err_cnt  = 0;  // failed checks over the run
  int unsigned test_cnt = 0;
  int unsigned test_bad = 0;  // tests with one or more failed checks

  // one galois step, hands back the bit shifted out
  function automatic logic lfsr_bit(inout logic [31:0] s);
    logic b;
    b = s[0];
    s = s >> 1;
    if (b) s = s ^ LFSR_TAPS;  // feedback into the tap positions
    return b;
  endfunction

  // full operand, one step per bit
  function automatic secp256k1_pkg::word_t lfsr_word(inout logic [31:0] s);
    secp256k1_pkg::word_t w;
    for (int i = 0; i < $bits(w); i++) begin
      w[i] = lfsr_bit(s);
    end
    return w;
  endfunction

  // (a*b) mod m at full product width
  function automatic secp256k1_pkg::word_t mod_mul(
    input secp256k1_pkg::word_t a,
    input secp256k1_pkg::word_t b,
    input secp256k1_pkg::word_t m
  );
    secp256k1_pkg::prod_t x;
    x = secp256k1_pkg::prod_t'(a) * secp256k1_pkg::prod_t'(b);
    return secp256k1_pkg::word_t'(x % secp256k1_pkg::prod_t'(m));
  endfunction

  // what the DUT should hand back for one request
  function automatic secp256k1_pkg::mod_res_t expect_res(input secp256k1_pkg::mul_req_t r);
    secp256k1_pkg::mod_res_t e;
    secp256k1_pkg::word_t    m;
    m = (r.sel == secp256k1_pkg::MOD_P) ? secp256k1_pkg::P_MOD : secp256k1_pkg::N_MOD;
    e.res = mod_mul(r.a, r.b, m);
    e.tag = r.tag;  // tag and err ride along untouched
    e.err = r.err;
    return e;
  endfunction

endpackage

//--- hdl/secp256k1_mult_mod.sv
// secp256k1 modular multiplier top: karatsuba product, mod p or mod n, ordered output
`timescale 1ns/1ps

module secp256k1_mult_mod (
  input  logic                    i_clk,
  input  logic                    i_rst,
  input  secp256k1_pkg::mul_req_t i_req,
  input  logic                    i_val,
  output logic                    o_rdy,
  output secp256k1_pkg::mod_res_t o_res,
  output logic                    o_val,
  input  logic                    i_rdy
);

  secp256k1_pkg::prod_req_t prod;
  logic                     prod_val;
  logic                     p_val, n_val;     // steered valids
  secp256k1_pkg::mod_res_t  p_res, n_res;
  logic                     p_res_val, n_res_val;
  logic                     en;               // shared advance

  karatsuba_mult mult_i (
    .i_clk  (i_clk),
    .i_rst  (i_rst),
    .i_en   (en),
    .i_req  (i_req),
    .i_val  (i_val),
    .o_prod (prod),
    .o_val  (prod_val)
  );

  // sel decodes to one reducer, both see the same data
  assign p_val = prod_val && (prod.sel == secp256k1_pkg::MOD_P);
  assign n_val = prod_val && (prod.sel == secp256k1_pkg::MOD_N);

  mod_p_fold red_p_i (
    .i_clk (i_clk), .i_rst (i_rst), .i_en (en),
    .i_prod(prod),  .i_val (p_val),
    .o_res (p_res), .o_val (p_res_val)
  );

  mod_n_barrett red_n_i (
    .i_clk (i_clk), .i_rst (i_rst), .i_en (en),
    .i_prod(prod),  .i_val (n_val),
    .o_res (n_res), .o_val (n_res_val)
  );

  result_merge merge_i (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_p_res (p_res),
    .i_p_val (p_res_val),
    .i_n_res (n_res),
    .i_n_val (n_res_val),
    .i_rdy   (i_rdy),
    .o_en    (en),
    .o_res   (o_res),
    .o_val   (o_val)
  );

  assign o_rdy = en;  // input accepted whenever the pipe moves

endmodule

//--- hdl/result_merge.sv
// merges both reducer streams into one output register, drives the advance enable
`timescale 1ns/1ps

module result_merge (
  input  logic                    i_clk,
  input  logic                    i_rst,
  input  secp256k1_pkg::mod_res_t i_p_res,
  input  logic                    i_p_val,
  input  secp256k1_pkg::mod_res_t i_n_res,
  input  logic                    i_n_val,
  input  logic                    i_rdy,
  output logic                    o_en,    // whole pipe moves on this
  output secp256k1_pkg::mod_res_t o_res,
  output logic                    o_val
);

  secp256k1_pkg::word_t res_q;
  secp256k1_pkg::tag_t  tag_q;
  logic                 err_q;

  // advance when the output slot is free or being drained
  assign o_en = !o_val || i_rdy;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_val <= 1'b0;
      err_q <= 1'b0;
    end else if (o_en) begin
      o_val <= i_p_val || i_n_val;
      err_q <= i_p_val ? i_p_res.err : i_n_res.err;
    end
  end

  // payload, no reset
  always_ff @(posedge i_clk) begin
    if (o_en) begin
      res_q <= i_p_val ? i_p_res.res : i_n_res.res;
      tag_q <= i_p_val ? i_p_res.tag : i_n_res.tag;
    end
  end

  assign o_res = '{res: res_q, tag: tag_q, err: err_q};

  // steering sends each product to one reducer, equal depth keeps them apart
  a_no_collide: assert property (@(posedge i_clk) disable iff (i_rst)
    !(i_p_val && i_n_val));

  // held under back-pressure
  a_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    o_val && !i_rdy |=> o_val && $stable(o_res));

endmodule

//--- hdl/mod_n_barrett.sv
// three-stage barrett reduction of a 512-bit product modulo n
`timescale 1ns/1ps
`include "modmul_macros.svh"

module mod_n_barrett (
  input  logic                     i_clk,
  input  logic                     i_rst,
  input  logic                     i_en,
  input  secp256k1_pkg::prod_req_t i_prod,
  input  logic                     i_val,
  output secp256k1_pkg::mod_res_t  o_res,
  output logic                     o_val
);

  localparam int W   = `MODMUL_W;
  localparam int PW  = `MODMUL_PROD_W;
  localparam int LAT = `MODMUL_RED_LAT;
  localparam int QW  = W + 1;        // q1 and quotient width
  localparam int MW  = 2 * QW;       // q1 * mu
  localparam int RW  = W + 2;        // remainder < 3n fits here

  if (LAT != 3) begin : g_lat_chk
    $error("mod_n_barrett is built for MODMUL_RED_LAT = 3");
  end

  logic [QW-1:0]       q1;      // top 257 bits of x
  logic [MW-1:0]       qmu;     // q1 * mu
  logic [QW-1:0]       q_q;     // quotient estimate
  logic [RW-1:0]       xl_q;    // low bits of x, enough for the remainder
  logic [RW-1:0]       qn_lo;   // q*n mod 2^258
  logic [RW-1:0]       r_q;     // x - q*n, in [0, 3n)
  logic [RW-1:0]       t;
  secp256k1_pkg::word_t res_q;

  logic [LAT-1:0]      v_q;
  logic [LAT-1:0]      err_q;
  secp256k1_pkg::tag_t tag_q [LAT];

  // stage 1: q = ((x >> 255) * mu) >> 257
  assign q1  = i_prod.prod[PW-1:W-1];
  assign qmu = MW'(q1) * MW'(secp256k1_pkg::MU_N);

  always_ff @(posedge i_clk) begin
    if (i_en) begin
      q_q  <= qmu[MW-1:W+1];
      xl_q <= i_prod.prod[RW-1:0];
    end
  end

  // stage 2: low bits only, the true remainder is small
  assign qn_lo = RW'(q_q) * RW'(secp256k1_pkg::N_MOD);

  always_ff @(posedge i_clk) begin
    if (i_en) begin
      r_q <= xl_q - qn_lo;
    end
  end

  // stage 3: subtract n up to twice
  always_comb begin
    t = r_q;
    if (t >= RW'(secp256k1_pkg::N_MOD)) t = t - RW'(secp256k1_pkg::N_MOD);
    if (t >= RW'(secp256k1_pkg::N_MOD)) t = t - RW'(secp256k1_pkg::N_MOD);
  end

  always_ff @(posedge i_clk) begin
    if (i_en) begin
      res_q <= t[W-1:0];
    end
  end

  // valid and err, reset
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      v_q   <= '0;
      err_q <= '0;
    end else if (i_en) begin
      v_q   <= {v_q[LAT-2:0], i_val};
      err_q <= {err_q[LAT-2:0], i_prod.err};
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_en) begin
      tag_q[0] <= i_prod.tag;
      for (int i = 1; i < LAT; i++) tag_q[i] <= tag_q[i-1];
    end
  end

  assign o_val = v_q[LAT-1];
  assign o_res = '{res: res_q, tag: tag_q[LAT-1], err: err_q[LAT-1]};

  // estimate is never off by more than two n
  a_res_below_n: assert property (@(posedge i_clk) disable iff (i_rst)
    o_val |-> o_res.res < secp256k1_pkg::N_MOD);

endmodule

//--- hdl/mod_p_fold.sv
// three-stage reduction of a 512-bit product modulo p by folding
`timescale 1ns/1ps
`include "modmul_macros.svh"

module mod_p_fold (
  input  logic                     i_clk,
  input  logic                     i_rst,
  input  logic                     i_en,
  input  secp256k1_pkg::prod_req_t i_prod,
  input  logic                     i_val,
  output secp256k1_pkg::mod_res_t  o_res,
  output logic                     o_val
);

  localparam int W   = `MODMUL_W;
  localparam int PW  = `MODMUL_PROD_W;
  localparam int LAT = `MODMUL_RED_LAT;
  localparam int S1W = W + 34;  // hi*K + lo stays below 2^289
  localparam int S2W = W + 1;   // second fold, one carry bit
  localparam logic [32:0] FOLD_K = 33'h1_0000_03D1;  // 2^256 mod p = 2^32 + 977

  if (LAT != 3) begin : g_lat_chk
    $error("mod_p_fold is built for MODMUL_RED_LAT = 3");
  end

  logic [S1W-1:0]      s1_q;   // after first fold
  logic [S2W-1:0]      s2_q;   // after second fold
  logic [S2W-1:0]      t;      // final subtract
  secp256k1_pkg::word_t res_q;

  logic [LAT-1:0]      v_q;
  logic [LAT-1:0]      err_q;
  secp256k1_pkg::tag_t tag_q [LAT];

  // stage 1: hi*2^256 + lo -> hi*K + lo
  always_ff @(posedge i_clk) begin
    if (i_en) begin
      s1_q <= S1W'(i_prod.prod[PW-1:W]) * S1W'(FOLD_K) + S1W'(i_prod.prod[W-1:0]);
    end
  end

  // stage 2: fold the small overflow again
  always_ff @(posedge i_clk) begin
    if (i_en) begin
      s2_q <= S2W'(s1_q[S1W-1:W]) * S2W'(FOLD_K) + S2W'(s1_q[W-1:0]);
    end
  end

  // stage 3: at most two subtracts of p
  always_comb begin
    t = s2_q;
    if (t >= S2W'(secp256k1_pkg::P_MOD)) t = t - S2W'(secp256k1_pkg::P_MOD);
    if (t >= S2W'(secp256k1_pkg::P_MOD)) t = t - S2W'(secp256k1_pkg::P_MOD);
  end

  always_ff @(posedge i_clk) begin
    if (i_en) begin
      res_q <= t[W-1:0];  // below p here
    end
  end

  // valid and err, reset
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      v_q   <= '0;
      err_q <= '0;
    end else if (i_en) begin
      v_q   <= {v_q[LAT-2:0], i_val};
      err_q <= {err_q[LAT-2:0], i_prod.err};
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_en) begin
      tag_q[0] <= i_prod.tag;
      for (int i = 1; i < LAT; i++) tag_q[i] <= tag_q[i-1];
    end
  end

  assign o_val = v_q[LAT-1];
  assign o_res = '{res: res_q, tag: tag_q[LAT-1], err: err_q[LAT-1]};

  // fully reduced on every result
  a_res_below_p: assert property (@(posedge i_clk) disable iff (i_rst)
    o_val |-> o_res.res < secp256k1_pkg::P_MOD);

endmodule

//--- hdl/karatsuba_mult.sv
// two-level pipelined karatsuba-ofman 256x256 multiplier with sideband pipe
`timescale 1ns/1ps
`include "modmul_macros.svh"

module karatsuba_mult (
  input  logic                     i_clk,
  input  logic                     i_rst,
  input  logic                     i_en,    // pipeline advance
  input  secp256k1_pkg::mul_req_t  i_req,
  input  logic                     i_val,
  output secp256k1_pkg::prod_req_t o_prod,
  output logic                     o_val
);

  localparam int W   = `MODMUL_W;
  localparam int PW  = `MODMUL_PROD_W;
  localparam int LVL = `MODMUL_KO_LEVEL;
  localparam int HW  = W / 2;         // half split point
  localparam int QW  = W / 4;         // quarter split point
  localparam int XW  = HW + 1;        // half operand, room for the a_hi+a_lo sum
  localparam int XHW = XW - QW;       // upper quarter of a half operand
  localparam int SW  = XHW + 1;       // quarter sum
  localparam int QPW = 2 * SW;        // quarter product
  localparam int HPW = 2 * XW;        // half product

  // data path below is built for exactly two levels
  if (LVL != 2) begin : g_lvl_chk
    $error("karatsuba_mult supports MODMUL_KO_LEVEL = 2 only");
  end

  logic [2:0][XW-1:0]  xa, xb;                   // lo, hi, lo+hi halves
  logic [2:0][QPW-1:0] qlo_q, qhi_q, qmid_q;     // level 2 partials
  logic [HPW-1:0]      hp [3];                   // rebuilt half products
  secp256k1_pkg::prod_t prod_q;

  // sideband, same depth as the data
  logic [LVL-1:0]          v_q;
  logic [LVL-1:0]          err_q;
  secp256k1_pkg::mod_sel_e sel_q [LVL];
  secp256k1_pkg::tag_t     tag_q [LVL];

  // level 1: halves and the middle-term sums
  always_comb begin
    xa[0] = XW'(i_req.a[HW-1:0]);
    xa[1] = XW'(i_req.a[W-1:HW]);
    xa[2] = XW'(i_req.a[HW-1:0]) + XW'(i_req.a[W-1:HW]);
    xb[0] = XW'(i_req.b[HW-1:0]);
    xb[1] = XW'(i_req.b[W-1:HW]);
    xb[2] = XW'(i_req.b[HW-1:0]) + XW'(i_req.b[W-1:HW]);
  end

  // level 2: three quarter multiplies per half product, registered
  for (genvar i = 0; i < 3; i++) begin : g_quarter
    logic [QW-1:0]  al, bl;
    logic [XHW-1:0] ah, bh;
    logic [SW-1:0]  as, bs;
    assign al = xa[i][QW-1:0];
    assign ah = xa[i][XW-1:QW];
    assign bl = xb[i][QW-1:0];
    assign bh = xb[i][XW-1:QW];
    assign as = SW'(al) + SW'(ah);  // cross term sums
    assign bs = SW'(bl) + SW'(bh);

    always_ff @(posedge i_clk) begin
      if (i_en) begin
        qlo_q[i]  <= QPW'(al) * QPW'(bl);
        qhi_q[i]  <= QPW'(ah) * QPW'(bh);
        qmid_q[i] <= QPW'(as) * QPW'(bs);
      end
    end
  end

  // recombine quarters into halves, halves into the full product
  always_comb begin
    for (int i = 0; i < 3; i++) begin
      hp[i] = (HPW'(qhi_q[i]) << (2 * QW))
            + (HPW'(qmid_q[i] - qhi_q[i] - qlo_q[i]) << QW)
            + HPW'(qlo_q[i]);
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_en) begin
      prod_q <= (PW'(hp[1]) << W)
              + (PW'(hp[2] - hp[1] - hp[0]) << HW)  // exact, true value fits
              + PW'(hp[0]);
    end
  end

  // control bits, reset
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      v_q   <= '0;
      err_q <= '0;
    end else if (i_en) begin
      v_q   <= {v_q[LVL-2:0], i_val};
      err_q <= {err_q[LVL-2:0], i_req.err};
    end
  end

  // payload sideband, no reset
  always_ff @(posedge i_clk) begin
    if (i_en) begin
      sel_q[0] <= i_req.sel;
      tag_q[0] <= i_req.tag;
      for (int i = 1; i < LVL; i++) begin
        sel_q[i] <= sel_q[i-1];
        tag_q[i] <= tag_q[i-1];
      end
    end
  end

  assign o_val  = v_q[LVL-1];
  assign o_prod = '{prod: prod_q, sel: sel_q[LVL-1], tag: tag_q[LVL-1], err: err_q[LVL-1]};

  // nothing leaks out of the pipe across a reset
  a_val_low_after_rst: assert property (@(posedge i_clk) i_rst |=> !o_val);

endmodule

//--- hdl/secp256k1_pkg.sv
// secp256k1 modmul types: operand vectors, stream structs, moduli and barrett constant
`include "modmul_macros.svh"

package secp256k1_pkg;

  // plain vectors with a meaning
  typedef logic [`MODMUL_W-1:0]      word_t;  // operand or residue
  typedef logic [`MODMUL_PROD_W-1:0] prod_t;  // full product
  typedef logic [`MODMUL_CTL_W-1:0]  tag_t;   // caller tag

  // which reducer gets the product
  typedef enum logic {
    MOD_P = 1'b0,  // field prime
    MOD_N = 1'b1   // group order
  } mod_sel_e;

  // request into the multiplier
  typedef struct packed {
    word_t    a;
    word_t    b;
    mod_sel_e sel;
    tag_t     tag;
    logic     err;  // passed through untouched
  } mul_req_t;

  // multiplier output
  typedef struct packed {
    prod_t    prod;
    mod_sel_e sel;
    tag_t     tag;
    logic     err;
  } prod_req_t;

  // reducer output and top-level result
  typedef struct packed {
    word_t res;
    tag_t  tag;
    logic  err;
  } mod_res_t;

  // p = 2^256 - 2^32 - 977
  localparam word_t P_MOD =
    256'hFFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFE_FFFFFC2F;

  // curve group order
  localparam word_t N_MOD =
    256'hFFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFE_BAAEDCE6_AF48A03B_BFD25E8C_D0364141;

  // floor(2^512 / n), 257 bits
  localparam logic [`MODMUL_W:0] MU_N =
    257'h1_00000000_00000000_00000000_00000001_45512319_50B75FC4_402DA173_2FC9BEC0;

endpackage

//--- include/modmul_macros.svh
// modmul sizing macros: operand, product and tag widths, pipeline depths
`ifndef MODMUL_MACROS_SVH
`define MODMUL_MACROS_SVH

// operand and residue width
`define MODMUL_W 256

// full product width, twice the operand
`define MODMUL_PROD_W 512

// caller tag carried alongside each request
`define MODMUL_CTL_W 8

// karatsuba split levels, one register each
// level 1 = halves, level 2 = quarters
`define MODMUL_KO_LEVEL 2

// reducer depth, same for the fold and the barrett path
// equal depth keeps results in issue order
`define MODMUL_RED_LAT 3

// top-level latency with no back-pressure is
// KO_LEVEL + RED_LAT + 1 output register

`endif
